// ==== sim.f ====
hw/ip_rx_pkg.sv
hw/ip_hdr_capture.sv
hw/ip_hdr_check.sv
hw/ip_rx_ctrl.sv
hw/ip_payload_framer.sv
hw/ip_eth_rx.sv
testbench/ip_eth_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the IPv4 receiver testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --assert -f sim.f --top-module ip_eth_rx_tb \
    --Mdir obj_dir -o ip_eth_rx_tb &&
./obj_dir/ip_eth_rx_tb || exit 1

// ==== testbench/ip_eth_rx_tb.sv ====
// testbench for the IPv4 receiver
// walks a table of frames, builds each one and predicts the DUT response
// from the IPv4 rules, with random output back-pressure on selected rows
// inputs change on the falling edge, handshakes are judged there as well

`timescale 1ns/1ps

module ip_eth_rx_tb
    import ip_rx_pkg::*;
();

    localparam int NUM_ROWS = 13;

    // corruption kinds
    localparam int C_NONE = 0;
    localparam int C_VER  = 1;
    localparam int C_IHL  = 2;
    localparam int C_CSUM = 3;
    localparam int C_LEN  = 4;

    // error pulse codes
    localparam int P_HDR_EARLY = 1;
    localparam int P_PAY_EARLY = 2;
    localparam int P_BAD_HDR   = 3;
    localparam int P_BAD_CSUM  = 4;

    typedef struct packed {
        logic [15:0] pay_len;
        logic [15:0] ip_len;
        logic [2:0]  corrupt;
        logic [15:0] trunc;
        logic [15:0] extra;
        logic        user_last;
        logic        bp;
    } frame_row_t;

    logic       clk;
    logic       rst;
    logic       eth_hdr_valid;
    logic       eth_hdr_ready;
    eth_hdr_t   eth_hdr;
    logic       in_valid;
    logic       in_ready;
    byte_beat_t in_beat;
    logic       ip_hdr_valid;
    logic       ip_hdr_ready;
    ip_rx_hdr_t ip_hdr;
    logic       out_valid;
    logic       out_ready;
    byte_beat_t out_beat;
    logic       busy;
    logic       error_header_early_termination;
    logic       error_payload_early_termination;
    logic       error_invalid_header;
    logic       error_invalid_checksum;

    byte_beat_t  exp_beats [$];
    ip_rx_hdr_t  exp_hdrs [$];
    int          exp_pulses [$];
    logic [31:0] rng;
    logic        bp_on;
    logic        busy_exp;
    logic        frame_dropped;
    int          cycle_count;
    int          timeout_limit;

    ip_eth_rx DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic frame_row_t make_row(input int pay, input int len, input int corrupt,
                                            input int trunc, input int extra,
                                            input int user_last, input int bp);
        frame_row_t r;
        r.pay_len   = 16'(pay);
        r.ip_len    = 16'(len);
        r.corrupt   = 3'(corrupt);
        r.trunc     = 16'(trunc);
        r.extra     = 16'(extra);
        r.user_last = 1'(user_last);
        r.bp        = 1'(bp);
        return r;
    endfunction

    // payload, total length, corruption, truncation, trailing, user on last, back-pressure
    function automatic frame_row_t table_row(input int idx);
        case (idx)
            0:       return make_row(12, 32, C_NONE, 0, 0, 0, 0);
            1:       return make_row(12, 32, C_NONE, 0, 0, 0, 1);
            2:       return make_row(8, 28, C_VER, 0, 0, 0, 0);
            3:       return make_row(5, 25, C_NONE, 0, 0, 0, 1);
            4:       return make_row(6, 26, C_IHL, 0, 0, 0, 0);
            5:       return make_row(6, 26, C_LEN, 0, 0, 0, 0);
            6:       return make_row(10, 30, C_CSUM, 0, 0, 0, 1);
            7:       return make_row(10, 30, C_NONE, 9, 0, 0, 0);
            8:       return make_row(10, 40, C_NONE, 0, 0, 0, 1);
            9:       return make_row(7, 27, C_NONE, 0, 5, 1, 1);
            10:      return make_row(4, 24, C_NONE, 0, 0, 1, 0);
            11:      return make_row(15, 35, C_NONE, 28, 0, 0, 1);
            default: return make_row(40, 60, C_NONE, 0, 0, 0, 1);
        endcase
    endfunction

    // bytes actually sent for a row, header included
    function automatic int frame_bytes(input frame_row_t r);
        int n;
        n = IP_HDR_BYTES + int'(r.pay_len) + int'(r.extra);
        if (r.trunc != 16'd0) begin
            n = int'(r.trunc);
        end
        return n;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ones'-complement sum of the ten header words
    function automatic logic [15:0] ones_sum(input logic [159:0] bits);
        logic [31:0] s;
        s = '0;
        for (int w = 0; w < 10; w++) begin
            s = s + 32'(bits[16*w +: 16]);
        end
        while (s[31:16] != 16'd0) begin
            s = 32'(s[15:0]) + 32'(s[31:16]);
        end
        return s[15:0];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [271:0] got,
                               input logic [271:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %0h expected %0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic accept_pulse(input string name, input int code);
        int exp_code;
        if (exp_pulses.size() == 0) begin
            fail_run($sformatf("%s pulsed while no error was expected", name));
        end else begin
            exp_code = exp_pulses.pop_front();
            check_value(name, 272'(code), 272'(exp_code));
        end
    endtask

    // outputs are stable at the falling edge, valid and ready here decide the next transfer
    task automatic watch_outputs();
        byte_beat_t exp_beat;
        ip_rx_hdr_t exp_hdr;
        // busy runs from the eth header transfer to the frame's final byte
        check_value("busy", 272'(busy), 272'(busy_exp));
        if (out_valid && out_ready) begin
            if (exp_beats.size() == 0) begin
                fail_run("a payload byte came out where no byte was expected");
            end else begin
                exp_beat = exp_beats.pop_front();
                check_value("out_beat", 272'(out_beat), 272'(exp_beat));
                if (exp_beat.last) begin
                    busy_exp = 1'b0;
                end
            end
        end
        if (ip_hdr_valid && ip_hdr_ready) begin
            if (exp_hdrs.size() == 0) begin
                fail_run("an ip header came out where no header was expected");
            end else begin
                exp_hdr = exp_hdrs.pop_front();
                check_value("ip_hdr", 272'(ip_hdr), 272'(exp_hdr));
            end
        end
        if (error_header_early_termination) begin
            accept_pulse("error_header_early_termination", P_HDR_EARLY);
        end
        if (error_payload_early_termination) begin
            accept_pulse("error_payload_early_termination", P_PAY_EARLY);
        end
        if (error_invalid_header) begin
            accept_pulse("error_invalid_header", P_BAD_HDR);
        end
        if (error_invalid_checksum) begin
            accept_pulse("error_invalid_checksum", P_BAD_CSUM);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            fail_run($sformatf("timeout after %0d cycles, an expected output never came",
                               cycle_count));
        end else begin
            if (bp_on) begin
                rng          = xorshift32(rng);
                out_ready    = rng[4];
                ip_hdr_ready = rng[9];
            end else begin
                out_ready    = 1'b1;
                ip_hdr_ready = 1'b1;
            end
            watch_outputs();
        end
    endtask

    task automatic send_eth_header(input eth_hdr_t h);
        eth_hdr       = h;
        eth_hdr_valid = 1'b1;
        while (!eth_hdr_ready) begin
            next_cycle();
        end
        busy_exp = 1'b1;
        next_cycle();
        eth_hdr_valid = 1'b0;
    endtask

    task automatic send_byte(input byte_beat_t b);
        in_beat  = b;
        in_valid = 1'b1;
        while (!in_ready) begin
            next_cycle();
        end
        // a dropped frame is over once its final input byte is taken
        if (b.last && frame_dropped) begin
            busy_exp = 1'b0;
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic build_and_send_frame(input int idx);
        frame_row_t   r;
        eth_hdr_t     eth;
        ip_hdr_t      ip;
        ip_rx_hdr_t   hdr_exp;
        logic [159:0] ip_bits;
        byte_beat_t   fb [$];
        byte_beat_t   beat;
        int           n;
        int           avail;
        int           want;

        r     = table_row(idx);
        bp_on = r.bp;
        rng   = xorshift32(rng);

        eth.dest_mac = {40'h02_00_5e_00_01, 8'(idx)};
        eth.src_mac  = 48'h02_00_00_00_aa_bb;
        eth.eth_type = 16'h0800;

        ip                = '0;
        ip.version        = (int'(r.corrupt) == C_VER) ? 4'd6 : 4'd4;
        ip.ihl            = (int'(r.corrupt) == C_IHL) ? 4'd6 : 4'd5;
        ip.length         = (int'(r.corrupt) == C_LEN) ? 16'd20 : r.ip_len;
        ip.identification = rng[15:0];
        ip.flags          = 3'b010;
        ip.ttl            = 8'd64;
        ip.protocol       = 8'd17;
        ip.source_ip      = {16'hc0a8, rng[31:16]};
        ip.dest_ip        = 32'hc0a8_0102;
        ip.header_checksum = ~ones_sum(ip);
        if (int'(r.corrupt) == C_CSUM) begin
            ip.header_checksum = ip.header_checksum ^ 16'h0001;
        end
        ip_bits = ip;

        // header bytes first byte most significant, then an incrementing payload
        n = frame_bytes(r);
        for (int i = 0; i < n; i++) begin
            if (i < IP_HDR_BYTES) begin
                beat.data = ip_bits[159 - 8*i -: 8];
            end else begin
                beat.data = 8'(r.ip_len) + 8'(i - IP_HDR_BYTES);
            end
            beat.last = (i == n - 1);
            beat.user = (i == n - 1) && r.user_last;
            fb.push_back(beat);
        end

        // reference model
        frame_dropped = 1'b1;
        if (n <= IP_HDR_BYTES) begin
            exp_pulses.push_back(P_HDR_EARLY);
        end else if (ip.version != 4'd4 || ip.ihl != 4'd5 || ip.length <= 16'd20) begin
            exp_pulses.push_back(P_BAD_HDR);
        end else if (ones_sum(ip) != 16'hffff) begin
            exp_pulses.push_back(P_BAD_CSUM);
        end else begin
            frame_dropped = 1'b0;
            hdr_exp.eth   = eth;
            hdr_exp.ip    = ip;
            exp_hdrs.push_back(hdr_exp);
            avail = n - IP_HDR_BYTES;
            want  = int'(ip.length) - IP_HDR_BYTES;
            if (avail < want) begin
                for (int i = 0; i < avail; i++) begin
                    beat = fb[IP_HDR_BYTES + i];
                    if (i == avail - 1) begin
                        beat.last = 1'b1;
                        beat.user = 1'b1;
                    end
                    exp_beats.push_back(beat);
                end
                exp_pulses.push_back(P_PAY_EARLY);
            end else begin
                for (int i = 0; i < want; i++) begin
                    beat      = fb[IP_HDR_BYTES + i];
                    beat.last = (i == want - 1);
                    beat.user = beat.user | ((i == want - 1) && fb[n - 1].user);
                    exp_beats.push_back(beat);
                end
            end
        end

        send_eth_header(eth);
        for (int i = 0; i < n; i++) begin
            send_byte(fb[i]);
        end
    endtask

    initial begin
        int total_bytes;

        rst           = 1'b1;
        eth_hdr_valid = 1'b0;
        eth_hdr       = '0;
        in_valid      = 1'b0;
        in_beat       = '0;
        ip_hdr_ready  = 1'b0;
        out_ready     = 1'b0;
        rng           = 32'd54968;
        bp_on         = 1'b0;
        busy_exp      = 1'b0;
        frame_dropped = 1'b0;
        cycle_count   = 0;

        total_bytes = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_bytes = total_bytes + frame_bytes(table_row(i));
        end
        timeout_limit = 40 * total_bytes + 200;

        @(negedge clk);
        check_value("eth_hdr_ready", 272'(eth_hdr_ready), 272'(1'b0));
        check_value("in_ready", 272'(in_ready), 272'(1'b0));
        check_value("ip_hdr_valid", 272'(ip_hdr_valid), 272'(1'b0));
        check_value("out_valid", 272'(out_valid), 272'(1'b0));
        check_value("busy", 272'(busy), 272'(1'b0));
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_value("eth_hdr_ready", 272'(eth_hdr_ready), 272'(1'b0));
        next_cycle();
        check_value("eth_hdr_ready", 272'(eth_hdr_ready), 272'(1'b1));

        for (int i = 0; i < NUM_ROWS; i++) begin
            build_and_send_frame(i);
        end

        // drain what is still in flight, then watch for stray outputs
        while (exp_beats.size() != 0 || exp_hdrs.size() != 0 ||
               exp_pulses.size() != 0 || busy) begin
            next_cycle();
        end
        repeat (10) next_cycle();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== hw/ip_eth_rx.sv ====
// IPv4 receiver top level
// takes an Ethernet header and its payload bytes, checks the IPv4 header
// and hands out the combined header followed by the IP payload
// status pulses report early ends and bad headers

`timescale 1ns/1ps

module ip_eth_rx
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       eth_hdr_valid,
    output logic       eth_hdr_ready,
    input  eth_hdr_t   eth_hdr,

    input  logic       in_valid,
    output logic       in_ready,
    input  byte_beat_t in_beat,

    output logic       ip_hdr_valid,
    input  logic       ip_hdr_ready,
    output ip_rx_hdr_t ip_hdr,

    output logic       out_valid,
    input  logic       out_ready,
    output byte_beat_t out_beat,

    output logic       busy,
    output logic       error_header_early_termination,
    output logic       error_payload_early_termination,
    output logic       error_invalid_header,
    output logic       error_invalid_checksum
);

    logic    eth_take;
    logic    hdr_take;
    logic    hdr_full;
    logic    format_ok;
    logic    checksum_ok;
    logic    payload_take;
    logic    payload_room;
    logic    payload_done;
    ip_hdr_u hdr_words;

    assign eth_take = eth_hdr_valid && eth_hdr_ready;

    ip_rx_ctrl u_ctrl (
        .clk                            (clk),
        .rst                            (rst),
        .eth_hdr_valid                  (eth_hdr_valid),
        .eth_hdr_ready                  (eth_hdr_ready),
        .in_valid                       (in_valid),
        .in_last                        (in_beat.last),
        .in_ready                       (in_ready),
        .ip_hdr_valid                   (ip_hdr_valid),
        .ip_hdr_ready                   (ip_hdr_ready),
        .hdr_take                       (hdr_take),
        .hdr_full                       (hdr_full),
        .format_ok                      (format_ok),
        .checksum_ok                    (checksum_ok),
        .payload_take                   (payload_take),
        .payload_room                   (payload_room),
        .payload_done                   (payload_done),
        .busy                           (busy),
        .error_header_early_termination (error_header_early_termination),
        .error_invalid_header           (error_invalid_header),
        .error_invalid_checksum         (error_invalid_checksum)
    );

    ip_hdr_capture u_capture (
        .clk       (clk),
        .rst       (rst),
        .eth_take  (eth_take),
        .eth_hdr   (eth_hdr),
        .hdr_take  (hdr_take),
        .in_data   (in_beat.data),
        .hdr       (ip_hdr),
        .hdr_words (hdr_words),
        .hdr_full  (hdr_full)
    );

    ip_hdr_check u_check (
        .hdr_words   (hdr_words),
        .format_ok   (format_ok),
        .checksum_ok (checksum_ok)
    );

    ip_payload_framer u_framer (
        .clk                 (clk),
        .rst                 (rst),
        .ip_length           (ip_hdr.ip.length),
        .payload_take        (payload_take),
        .in_beat             (in_beat),
        .payload_room        (payload_room),
        .payload_done        (payload_done),
        .error_payload_early (error_payload_early_termination),
        .out_valid           (out_valid),
        .out_ready           (out_ready),
        .out_beat            (out_beat)
    );

endmodule

// ==== hw/ip_payload_framer.sv ====
// payload framer for the IPv4 receiver
// counts payload bytes against the IP total length and marks the final one
// bytes past the IP length are swallowed, a short frame is flagged with user
// a two-entry buffer keeps input acceptance independent of output stalls

`timescale 1ns/1ps

module ip_payload_framer
    import ip_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic [15:0] ip_length,

    input  logic        payload_take,
    input  byte_beat_t  in_beat,
    output logic        payload_room,
    output logic        payload_done,

    output logic        error_payload_early,
    output logic        out_valid,
    input  logic        out_ready,
    output byte_beat_t  out_beat
);

    byte_beat_t  buf_mem [2];
    byte_beat_t  held;
    byte_beat_t  wr_beat;
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  count;
    logic [1:0]  occupancy;
    logic [15:0] remain;
    logic        active;
    logic        draining;
    logic        closed;
    logic        exhaust;
    logic        short_end;
    logic        wr_en;
    logic        rd_en;

    // remain counts bytes still owed by the IP length
    assign exhaust   = (remain == 16'd1);
    assign short_end = payload_take && !draining && in_beat.last && !exhaust;

    // the held byte counts as in flight while trailing bytes are swallowed
    assign occupancy    = count + {1'b0, draining};
    assign payload_room = !closed && (occupancy < 2'd2);

    // the exhausting byte goes to the hold register unless the input ends with it
    assign wr_en = payload_take && (draining ? in_beat.last : (in_beat.last || !exhaust));

    always_comb begin
        if (draining) begin
            wr_beat      = held;
            wr_beat.user = held.user | in_beat.user;
        end else begin
            wr_beat      = in_beat;
            wr_beat.last = in_beat.last | exhaust;
            wr_beat.user = in_beat.user | short_end;
        end
    end

    assign out_valid    = (count != 2'd0);
    assign out_beat     = buf_mem[rd_ptr];
    assign rd_en        = out_valid && out_ready;
    assign payload_done = rd_en && out_beat.last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr              <= 1'b0;
            rd_ptr              <= 1'b0;
            count               <= '0;
            remain              <= '0;
            active              <= 1'b0;
            draining            <= 1'b0;
            closed              <= 1'b0;
            error_payload_early <= 1'b0;
        end else begin
            error_payload_early <= short_end;
            if (wr_en) begin
                wr_ptr <= !wr_ptr;
            end
            if (rd_en) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + 2'(wr_en) - 2'(rd_en);

            // between frames the count follows the captured length
            if (payload_take && !draining) begin
                active <= 1'b1;
                remain <= remain - 16'd1;
            end else if (!active) begin
                remain <= ip_length - 16'(IP_HDR_BYTES);
            end

            if (payload_take && !draining && exhaust && !in_beat.last) begin
                draining <= 1'b1;
            end else if (payload_take && draining && in_beat.last) begin
                draining <= 1'b0;
            end

            if (wr_en && wr_beat.last) begin
                closed <= 1'b1;
            end
            if (payload_done) begin
                active <= 1'b0;
                closed <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            buf_mem[wr_ptr] <= wr_beat;
        end
        if (payload_take && !draining && exhaust && !in_beat.last) begin
            held <= '{data: in_beat.data, last: 1'b1, user: in_beat.user};
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> (count != 2'd2)
    ) else $error("payload buffer written while full");

endmodule

// ==== hw/ip_rx_ctrl.sv ====
// frame sequencer for the IPv4 receiver
// steers input bytes to the header capture, the payload framer or nowhere
// and produces the ready, valid, busy and header status signals
// the check cycle is the header phase cycle in which hdr_full is high

`timescale 1ns/1ps

module ip_rx_ctrl
    import ip_rx_pkg::*;
(
    input  logic clk,
    input  logic rst,

    input  logic eth_hdr_valid,
    output logic eth_hdr_ready,

    input  logic in_valid,
    input  logic in_last,
    output logic in_ready,

    output logic ip_hdr_valid,
    input  logic ip_hdr_ready,

    output logic hdr_take,
    input  logic hdr_full,
    input  logic format_ok,
    input  logic checksum_ok,

    output logic payload_take,
    input  logic payload_room,
    input  logic payload_done,

    output logic busy,
    output logic error_header_early_termination,
    output logic error_invalid_header,
    output logic error_invalid_checksum
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HEADER,
        S_PAYLOAD,
        S_DISCARD
    } state_t;

    state_t state;
    state_t state_next;
    logic   check;
    logic   good_hdr;
    logic   ip_hdr_valid_next;

    assign check    = (state == S_HEADER) && hdr_full;
    assign good_hdr = check && format_ok && checksum_ok;

    // no input accepted in the check cycle
    assign in_ready = ((state == S_HEADER) && !hdr_full) ||
                      (state == S_DISCARD) ||
                      ((state == S_PAYLOAD) && payload_room);

    assign hdr_take     = (state == S_HEADER) && !hdr_full && in_valid;
    assign payload_take = (state == S_PAYLOAD) && payload_room && in_valid;

    // header output holds until taken, payload does not wait for it
    assign ip_hdr_valid_next = (ip_hdr_valid && !ip_hdr_ready) || good_hdr;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (eth_hdr_valid && eth_hdr_ready) begin
                    state_next = S_HEADER;
                end
            end
            S_HEADER: begin
                if (check) begin
                    state_next = good_hdr ? S_PAYLOAD : S_DISCARD;
                end else if (hdr_take && in_last) begin
                    state_next = S_IDLE;
                end
            end
            S_PAYLOAD: begin
                if (payload_done) begin
                    state_next = S_IDLE;
                end
            end
            S_DISCARD: begin
                if (in_valid && in_last) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state                          <= S_IDLE;
            eth_hdr_ready                  <= 1'b0;
            ip_hdr_valid                   <= 1'b0;
            busy                           <= 1'b0;
            error_header_early_termination <= 1'b0;
            error_invalid_header           <= 1'b0;
            error_invalid_checksum         <= 1'b0;
        end else begin
            state         <= state_next;
            ip_hdr_valid  <= ip_hdr_valid_next;
            eth_hdr_ready <= (state_next == S_IDLE) && !ip_hdr_valid_next;
            busy          <= (state_next != S_IDLE);
            error_header_early_termination <= hdr_take && in_last;
            // format failure masks a checksum failure
            error_invalid_header   <= check && !format_ok;
            error_invalid_checksum <= check && format_ok && !checksum_ok;
        end
    end

    // the framer only finishes a payload that was handed to it
    a_done_in_payload: assert property (
        @(posedge clk) disable iff (rst)
        payload_done |-> (state == S_PAYLOAD)
    ) else $error("payload end reported outside the payload phase");

endmodule

// ==== hw/ip_hdr_check.sv ====
// header checker for the IPv4 receiver
// purely combinational, the sequencer samples it in the check cycle only
// format_ok covers version, IHL and minimum total length
// checksum_ok is the ones'-complement sum over all ten header words

`timescale 1ns/1ps

module ip_hdr_check
    import ip_rx_pkg::*;
(
    input  ip_hdr_u hdr_words,
    output logic    format_ok,
    output logic    checksum_ok
);

    localparam int HDR_WORDS = IP_HDR_BYTES / 2;

    logic [19:0] word_sum;
    logic [16:0] fold_once;
    logic [15:0] fold_twice;

    // zero-length payloads are rejected along with the bad formats
    assign format_ok = (hdr_words.fields.version == IP_VERSION) &&
                       (hdr_words.fields.ihl == IP_IHL) &&
                       (hdr_words.fields.length > 16'(IP_HDR_BYTES));

    // plain sum first, end-around carries folded afterwards
    always_comb begin
        word_sum = '0;
        for (int i = 0; i < HDR_WORDS; i++) begin
            word_sum = word_sum + 20'(hdr_words.words[i]);
        end
    end

    // ten words carry at most 4 bits, two folds are enough
    assign fold_once  = 17'(word_sum[15:0]) + 17'(word_sum[19:16]);
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

    assign checksum_ok = (fold_twice == 16'hffff);

endmodule

// ==== hw/ip_hdr_capture.sv ====
// header capture for the IPv4 receiver
// holds the Ethernet header and the 20 IP header bytes of the current frame
// the captured header stays stable until the next Ethernet header is taken

`timescale 1ns/1ps

module ip_hdr_capture
    import ip_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // ethernet header from the input channel
    input  logic       eth_take,
    input  eth_hdr_t   eth_hdr,

    // ip header bytes steered here by the sequencer
    input  logic       hdr_take,
    input  logic [7:0] in_data,

    output ip_rx_hdr_t hdr,
    output ip_hdr_u    hdr_words,
    output logic       hdr_full
);

    eth_hdr_t   eth_q;
    ip_hdr_u    ip_q;
    logic [4:0] byte_count;
    logic       last_hdr_byte;

    // the byte in flight completes the fixed header
    assign last_hdr_byte = hdr_take && (byte_count == 5'(IP_HDR_BYTES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_count <= '0;
            hdr_full   <= 1'b0;
        end else begin
            hdr_full <= last_hdr_byte;
            if (eth_take) begin
                byte_count <= '0;
            end else if (hdr_take) begin
                byte_count <= byte_count + 5'd1;
            end
        end
    end

    // header contents only, qualified by the counter and the sequencer
    always_ff @(posedge clk) begin
        if (eth_take) begin
            eth_q <= eth_hdr;
        end
        // first byte ends up in the top bits once all 20 are in
        if (hdr_take) begin
            ip_q <= {ip_q[$bits(ip_hdr_u)-9:0], in_data};
        end
    end

    assign hdr.eth   = eth_q;
    assign hdr.ip    = ip_q.fields;
    assign hdr_words = ip_q;

    // the sequencer must stop steering bytes here once the header is complete
    a_count_bounded: assert property (
        @(posedge clk) disable iff (rst)
        byte_count <= 5'(IP_HDR_BYTES)
    ) else $error("ip header byte count ran past the fixed header length");

endmodule

// ==== hw/ip_rx_pkg.sv ====
// shared types and protocol constants for the IPv4 receiver
// every RTL block imports this package in its module header

package ip_rx_pkg;

    // fixed IPv4 header without options
    localparam int IP_HDR_BYTES = 20;
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;

    // one byte on a payload stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } byte_beat_t;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // fields in wire order, first header byte in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // same captured bits read as fields or as checksum words
    typedef union packed {
        ip_hdr_t          fields;
        logic [9:0][15:0] words;
    } ip_hdr_u;

    typedef struct packed {
        eth_hdr_t eth;
        ip_hdr_t  ip;
    } ip_rx_hdr_t;

endpackage
